/* build.f */
+incdir+source
source/fpu_pkg.sv
source/fpu_issue_decoder.sv
source/fpu_sgnj_lane.sv
source/fpr_file.sv
source/fpu_cluster.sv
testbench/tb_fpu_cluster.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the FPU cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_fpu_cluster -Mdir obj_dir -f build.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vtb_fpu_cluster)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation run failed with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Simulation PASSED"; then
  exit 0
fi
exit 1

/* source/fpr_file.sv */
`include "fpu_config.svh"

module fpr_file
  import fpu_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_reset_n,

  input  rnid_t i_rd_addr1 [`FPU_LANES],
  input  rnid_t i_rd_addr2 [`FPU_LANES],
  output xlen_t o_rd_data1 [`FPU_LANES],
  output xlen_t o_rd_data2 [`FPU_LANES],

  input  logic  i_wr_valid [`FPU_LANES],
  input  logic  i_wr_fpr   [`FPU_LANES],
  input  rnid_t i_wr_rd    [`FPU_LANES],
  input  xlen_t i_wr_data  [`FPU_LANES]
);

  xlen_t r_regs [`FPR_NUM];
  logic  w_wr_en [`FPU_LANES];

  always_comb begin
    for (int l = 0; l < `FPU_LANES; l++) begin
      w_wr_en[l] = i_wr_valid[l] & i_wr_fpr[l];
    end
  end

  // Later lane overrides, so lane 1 wins on a shared rd
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int r = 0; r < `FPR_NUM; r++) begin
        r_regs[r] <= '0;
      end
    end else begin
      for (int l = 0; l < `FPU_LANES; l++) begin
        if (w_wr_en[l]) begin
          r_regs[i_wr_rd[l]] <= i_wr_data[l];
        end
      end
    end
  end

  // Write-through bypass with the same lane priority
  always_comb begin
    for (int p = 0; p < `FPU_LANES; p++) begin
      o_rd_data1[p] = r_regs[i_rd_addr1[p]];
      o_rd_data2[p] = r_regs[i_rd_addr2[p]];
      for (int l = 0; l < `FPU_LANES; l++) begin
        if (w_wr_en[l] && (i_wr_rd[l] == i_rd_addr1[p])) begin
          o_rd_data1[p] = i_wr_data[l];
        end
        if (w_wr_en[l] && (i_wr_rd[l] == i_rd_addr2[p])) begin
          o_rd_data2[p] = i_wr_data[l];
        end
      end
    end
  end

endmodule

/* source/fpu_cluster.sv */
`include "fpu_config.svh"

module fpu_cluster
  import fpu_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_reset_n,

  input  logic        i_inst_valid [`FPU_LANES],
  input  logic [31:0] i_inst       [`FPU_LANES],
  input  xlen_t       i_int_data   [`FPU_LANES],

  output logic        o_wb_valid   [`FPU_LANES],
  output logic        o_wb_fpr     [`FPU_LANES],
  output rnid_t       o_wb_rd      [`FPU_LANES],
  output xlen_t       o_wb_data    [`FPU_LANES]
);

  // EX0 from the decoder
  logic    w_ex0_valid    [`FPU_LANES];
  fpu_op_t w_ex0_op       [`FPU_LANES];
  rnid_t   w_ex0_rs1      [`FPU_LANES];
  rnid_t   w_ex0_rs2      [`FPU_LANES];
  rnid_t   w_ex0_rd       [`FPU_LANES];
  xlen_t   w_ex0_int_data [`FPU_LANES];

  rnid_t   w_rd_addr1 [`FPU_LANES];
  rnid_t   w_rd_addr2 [`FPU_LANES];
  xlen_t   w_rd_data1 [`FPU_LANES];
  xlen_t   w_rd_data2 [`FPU_LANES];

  // EX3 write buses shared by forwarding, FPR file and write-back
  logic    w_wr_valid [`FPU_LANES];
  logic    w_wr_fpr   [`FPU_LANES];
  rnid_t   w_wr_rd    [`FPU_LANES];
  xlen_t   w_wr_data  [`FPU_LANES];

  fpu_issue_decoder u_decoder (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_inst_valid (i_inst_valid),
    .i_inst       (i_inst),
    .i_int_data   (i_int_data),
    .o_valid      (w_ex0_valid),
    .o_op         (w_ex0_op),
    .o_rs1        (w_ex0_rs1),
    .o_rs2        (w_ex0_rs2),
    .o_rd         (w_ex0_rd),
    .o_int_data   (w_ex0_int_data)
  );

  // ----------------------------------------
  // Lanes
  // ----------------------------------------
  for (genvar g = 0; g < `FPU_LANES; g++) begin : g_lane
    fpu_sgnj_lane u_lane (
      .i_clk       (i_clk),
      .i_reset_n   (i_reset_n),
      .i_valid     (w_ex0_valid[g]),
      .i_op        (w_ex0_op[g]),
      .i_rs1       (w_ex0_rs1[g]),
      .i_rs2       (w_ex0_rs2[g]),
      .i_rd        (w_ex0_rd[g]),
      .i_int_data  (w_ex0_int_data[g]),
      .o_rd_addr1  (w_rd_addr1[g]),
      .o_rd_addr2  (w_rd_addr2[g]),
      .i_rd_data1  (w_rd_data1[g]),
      .i_rd_data2  (w_rd_data2[g]),
      .i_fwd_valid (w_wr_valid),
      .i_fwd_fpr   (w_wr_fpr),
      .i_fwd_rd    (w_wr_rd),
      .i_fwd_data  (w_wr_data),
      .o_wr_valid  (w_wr_valid[g]),
      .o_wr_fpr    (w_wr_fpr[g]),
      .o_wr_rd     (w_wr_rd[g]),
      .o_wr_data   (w_wr_data[g])
    );

    assign o_wb_valid[g] = w_wr_valid[g];
    assign o_wb_fpr[g]   = w_wr_fpr[g];
    assign o_wb_rd[g]    = w_wr_rd[g];
    assign o_wb_data[g]  = w_wr_data[g];
  end

  fpr_file u_fpr_file (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_rd_addr1 (w_rd_addr1),
    .i_rd_addr2 (w_rd_addr2),
    .o_rd_data1 (w_rd_data1),
    .o_rd_data2 (w_rd_data2),
    .i_wr_valid (w_wr_valid),
    .i_wr_fpr   (w_wr_fpr),
    .i_wr_rd    (w_wr_rd),
    .i_wr_data  (w_wr_data)
  );

endmodule

/* source/fpu_config.svh */
`ifndef FPU_CONFIG_SVH
`define FPU_CONFIG_SVH

// ----------------------------------------
// Cluster sizing
// ----------------------------------------

// One lane per issue slot
`define FPU_LANES 2

// Architectural FP registers
`define FPR_NUM 32

// Register data width
`define FPU_XLEN 64

`endif

/* source/fpu_issue_decoder.sv */
`include "fpu_config.svh"

module fpu_issue_decoder
  import fpu_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_reset_n,

  input  logic    i_inst_valid [`FPU_LANES],
  input  logic [31:0] i_inst     [`FPU_LANES],
  input  xlen_t   i_int_data   [`FPU_LANES],

  output logic    o_valid      [`FPU_LANES],
  output fpu_op_t o_op         [`FPU_LANES],
  output rnid_t   o_rs1        [`FPU_LANES],
  output rnid_t   o_rs2        [`FPU_LANES],
  output rnid_t   o_rd         [`FPU_LANES],
  output xlen_t   o_int_data   [`FPU_LANES]
);

  localparam logic [6:0] OPC_OP_FP = 7'b1010011;
  localparam logic [6:0] F7_SGNJ_S = 7'b0010000;
  localparam logic [6:0] F7_SGNJ_D = 7'b0010001;
  localparam logic [6:0] F7_MV_W_X = 7'b1111000;
  localparam logic [6:0] F7_MV_X_W = 7'b1110000;

  fpu_op_t w_op [`FPU_LANES];

  function automatic fpu_op_t decode_op(input logic [31:0] inst);
    logic [6:0] funct7;
    logic [2:0] funct3;
    logic       dbl;
    fpu_op_t    op;
    funct7 = inst[31:25];
    funct3 = inst[14:12];
    dbl    = funct7[0];  // fmt bit of the sign injections
    op     = OP_NONE;
    if (inst[6:0] == OPC_OP_FP) begin
      case (funct7)
        F7_SGNJ_S, F7_SGNJ_D: begin
          case (funct3)
            3'b000:  op = dbl ? OP_FSGNJ_D  : OP_FSGNJ_S;
            3'b001:  op = dbl ? OP_FSGNJN_D : OP_FSGNJN_S;
            3'b010:  op = dbl ? OP_FSGNJX_D : OP_FSGNJX_S;
            default: op = OP_NONE;
          endcase
        end
        F7_MV_W_X: op = (funct3 == 3'b000) ? OP_FMV_W_X : OP_NONE;
        F7_MV_X_W: op = (funct3 == 3'b000) ? OP_FMV_X_W : OP_NONE;
        default:   op = OP_NONE;
      endcase
    end
    return op;
  endfunction

  always_comb begin
    for (int l = 0; l < `FPU_LANES; l++) begin
      w_op[l] = i_inst_valid[l] ? decode_op(i_inst[l]) : OP_NONE;
    end
  end

  // ----------------------------------------
  // EX0 registers
  // ----------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int l = 0; l < `FPU_LANES; l++) begin
        o_valid[l] <= 1'b0;
        o_op[l]    <= OP_NONE;
      end
    end else begin
      for (int l = 0; l < `FPU_LANES; l++) begin
        o_valid[l] <= (w_op[l] != OP_NONE);  // Unknown words dropped here
        o_op[l]    <= w_op[l];
      end
    end
  end

  always_ff @(posedge i_clk) begin
    for (int l = 0; l < `FPU_LANES; l++) begin
      o_rs1[l]      <= i_inst[l][19:15];
      o_rs2[l]      <= i_inst[l][24:20];
      o_rd[l]       <= i_inst[l][11:7];
      o_int_data[l] <= i_int_data[l];
    end
  end

endmodule

/* source/fpu_pkg.sv */
`include "fpu_config.svh"

package fpu_pkg;

  // ----------------------------------------
  // Pipe operations
  // ----------------------------------------
  typedef enum logic [3:0] {
    OP_NONE     = 4'd0,
    OP_FMV_W_X  = 4'd1,  // Integer to NaN-boxed single
    OP_FMV_X_W  = 4'd2,  // Single to sign-extended integer
    OP_FSGNJ_S  = 4'd3,
    OP_FSGNJN_S = 4'd4,
    OP_FSGNJX_S = 4'd5,
    OP_FSGNJ_D  = 4'd6,
    OP_FSGNJN_D = 4'd7,
    OP_FSGNJX_D = 4'd8
  } fpu_op_t;

  // ----------------------------------------
  // Data and register index
  // ----------------------------------------
  typedef logic [`FPU_XLEN-1:0] xlen_t;
  typedef logic [4:0]           rnid_t;

  // Quiet NaN in a NaN box
  localparam xlen_t CANON_NAN_S = 64'hffff_ffff_7fc0_0000;

endpackage

/* source/fpu_sgnj_lane.sv */
`include "fpu_config.svh"

module fpu_sgnj_lane
  import fpu_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_reset_n,

  input  logic    i_valid,
  input  fpu_op_t i_op,
  input  rnid_t   i_rs1,
  input  rnid_t   i_rs2,
  input  rnid_t   i_rd,
  input  xlen_t   i_int_data,

  output rnid_t   o_rd_addr1,
  output rnid_t   o_rd_addr2,
  input  xlen_t   i_rd_data1,
  input  xlen_t   i_rd_data2,

  input  logic    i_fwd_valid [`FPU_LANES],
  input  logic    i_fwd_fpr   [`FPU_LANES],
  input  rnid_t   i_fwd_rd    [`FPU_LANES],
  input  xlen_t   i_fwd_data  [`FPU_LANES],

  output logic    o_wr_valid,
  output logic    o_wr_fpr,
  output rnid_t   o_wr_rd,
  output xlen_t   o_wr_data
);

  logic    r_ex1_valid;
  fpu_op_t r_ex1_op;
  rnid_t   r_ex1_rs1;
  rnid_t   r_ex1_rs2;
  rnid_t   r_ex1_rd;
  xlen_t   r_ex1_int_data;

  logic    r_ex2_valid;
  fpu_op_t r_ex2_op;
  rnid_t   r_ex2_rs1;
  rnid_t   r_ex2_rs2;
  rnid_t   r_ex2_rd;
  xlen_t   r_ex2_rs1_data;
  xlen_t   r_ex2_rs2_data;

  logic [`FPU_LANES-1:0] w_rs1_oh;
  logic [`FPU_LANES-1:0] w_rs2_oh;
  xlen_t   w_rs1_fwd;
  xlen_t   w_rs2_fwd;
  xlen_t   w_rs1;
  xlen_t   w_rs2;
  xlen_t   w_rs1_canon;
  xlen_t   w_rs2_canon;
  xlen_t   w_ex2_res;
  logic    w_ex2_fpr;

  logic    r_ex3_valid;
  logic    r_ex3_fpr;
  rnid_t   r_ex3_rd;
  xlen_t   r_ex3_data;

  // ----------------------------------------
  // EX1 register read
  // ----------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_valid <= 1'b0;
      r_ex1_op    <= OP_NONE;
      r_ex2_valid <= 1'b0;
      r_ex2_op    <= OP_NONE;
    end else begin
      r_ex1_valid <= i_valid;
      r_ex1_op    <= i_op;
      r_ex2_valid <= r_ex1_valid;
      r_ex2_op    <= r_ex1_op;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex1_rs1      <= i_rs1;
    r_ex1_rs2      <= i_rs2;
    r_ex1_rd       <= i_rd;
    r_ex1_int_data <= i_int_data;
    r_ex2_rs1      <= r_ex1_rs1;
    r_ex2_rs2      <= r_ex1_rs2;
    r_ex2_rd       <= r_ex1_rd;
    // fmv.w.x takes its source from the integer side
    r_ex2_rs1_data <= (r_ex1_op == OP_FMV_W_X) ? r_ex1_int_data : i_rd_data1;
    r_ex2_rs2_data <= i_rd_data2;
  end

  assign o_rd_addr1 = r_ex1_rs1;
  assign o_rd_addr2 = r_ex1_rs2;

  // ----------------------------------------
  // EX2 forwarding from EX3 buses
  // ----------------------------------------
  always_comb begin : fwd_select
    logic hit1;
    logic hit2;
    logic taken1;
    logic taken2;
    taken1    = 1'b0;
    taken2    = 1'b0;
    w_rs1_oh  = '0;
    w_rs2_oh  = '0;
    w_rs1_fwd = '0;
    w_rs2_fwd = '0;
    // Walk down so the highest lane claims the hit
    for (int l = `FPU_LANES - 1; l >= 0; l--) begin
      hit1 = i_fwd_valid[l] & i_fwd_fpr[l] & (i_fwd_rd[l] == r_ex2_rs1) &
             (r_ex2_op != OP_FMV_W_X);
      hit2 = i_fwd_valid[l] & i_fwd_fpr[l] & (i_fwd_rd[l] == r_ex2_rs2);
      w_rs1_oh[l] = hit1 & ~taken1;
      w_rs2_oh[l] = hit2 & ~taken2;
      taken1 = taken1 | hit1;
      taken2 = taken2 | hit2;
    end
    for (int l = 0; l < `FPU_LANES; l++) begin
      w_rs1_fwd = w_rs1_fwd | ({`FPU_XLEN{w_rs1_oh[l]}} & i_fwd_data[l]);
      w_rs2_fwd = w_rs2_fwd | ({`FPU_XLEN{w_rs2_oh[l]}} & i_fwd_data[l]);
    end
  end

  assign w_rs1 = |w_rs1_oh ? w_rs1_fwd : r_ex2_rs1_data;
  assign w_rs2 = |w_rs2_oh ? w_rs2_fwd : r_ex2_rs2_data;

  // Missing NaN box reads as canonical NaN
  assign w_rs1_canon = (&w_rs1[63:32]) ? w_rs1 : CANON_NAN_S;
  assign w_rs2_canon = (&w_rs2[63:32]) ? w_rs2 : CANON_NAN_S;

  always_comb begin
    w_ex2_fpr = 1'b1;
    case (r_ex2_op)
      OP_FMV_W_X:  w_ex2_res = {32'hffff_ffff, w_rs1[31:0]};
      OP_FMV_X_W: begin
        w_ex2_res = {{32{w_rs1[31]}}, w_rs1[31:0]};
        w_ex2_fpr = 1'b0;  // Goes to the integer side
      end
      OP_FSGNJ_S:  w_ex2_res = {w_rs1_canon[63:32], w_rs2_canon[31], w_rs1_canon[30:0]};
      OP_FSGNJN_S: w_ex2_res = {w_rs1_canon[63:32], ~w_rs2_canon[31], w_rs1_canon[30:0]};
      OP_FSGNJX_S: w_ex2_res = {w_rs1_canon[63:32], w_rs1_canon[31] ^ w_rs2_canon[31],
                                w_rs1_canon[30:0]};
      OP_FSGNJ_D:  w_ex2_res = {w_rs2[63], w_rs1[62:0]};
      OP_FSGNJN_D: w_ex2_res = {~w_rs2[63], w_rs1[62:0]};
      OP_FSGNJX_D: w_ex2_res = {w_rs1[63] ^ w_rs2[63], w_rs1[62:0]};
      default: begin
        w_ex2_res = '0;
        w_ex2_fpr = 1'b0;
      end
    endcase
  end

  // ----------------------------------------
  // EX3 write bus
  // ----------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex3_valid <= 1'b0;
      r_ex3_fpr   <= 1'b0;
    end else begin
      r_ex3_valid <= r_ex2_valid;
      r_ex3_fpr   <= w_ex2_fpr;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex3_rd   <= r_ex2_rd;
    r_ex3_data <= w_ex2_res;
  end

  assign o_wr_valid = r_ex3_valid;
  assign o_wr_fpr   = r_ex3_fpr;
  assign o_wr_rd    = r_ex3_rd;
  assign o_wr_data  = r_ex3_data;

endmodule

/* testbench/fpu_cluster_vectors.txt */
// Per slot: inst_valid inst int_data expect_valid expect_fpr expect_rd expect_data
// Slot 0 columns first, then slot 1; one line per issue cycle
0 00000000 0000000000000000 0 0 00 0000000000000000 0 00000000 0000000000000000 0 0 00 0000000000000000
1 F00000D3 000000003F800000 1 1 01 FFFFFFFF3F800000 1 F0000153 DEADBEEFC0000000 1 1 02 FFFFFFFFC0000000
1 F00001D3 1234567840490FDB 1 1 03 FFFFFFFF40490FDB 1 E00082D3 0000000000000000 1 0 05 000000003F800000
1 E0010353 0000000000000000 1 0 06 FFFFFFFFC0000000 1 20208253 0000000000000000 1 1 04 FFFFFFFFBF800000
1 204212D3 0000000000000000 1 1 05 FFFFFFFF3F800000 1 2041A353 0000000000000000 1 1 06 FFFFFFFFC0490FDB
1 220183D3 0000000000000000 1 1 07 7FFFFFFF40490FDB 1 22532453 0000000000000000 1 1 08 7FFFFFFFC0490FDB
1 201394D3 0000000000000000 1 1 09 FFFFFFFFFFC00000 1 20822553 0000000000000000 1 1 0A FFFFFFFFBF800000
1 227415D3 0000000000000000 1 1 0B FFFFFFFFC0490FDB 1 E0048653 0000000000000000 1 0 0C FFFFFFFFFFC00000
1 F0000653 0000000011111111 1 1 0C FFFFFFFF11111111 1 F0000653 0000000022222222 1 1 0C FFFFFFFF22222222
1 22C606D3 0000000000000000 1 1 0D FFFFFFFF22222222 1 002083D3 0000000000000000 0 0 00 0000000000000000
0 F00003D3 0000000000000055 0 0 00 0000000000000000 1 E0060753 0000000000000000 1 0 0E 0000000022222222
0 00000000 0000000000000000 0 0 00 0000000000000000 0 00000000 0000000000000000 0 0 00 0000000000000000
1 22738753 0000000000000000 1 1 0E 7FFFFFFF40490FDB 1 205617D3 0000000000000000 1 1 0F FFFFFFFFA2222222
1 F0000853 0000000080000001 1 1 10 FFFFFFFF80000001 1 F00008D3 000000007F7FFFFF 1 1 11 FFFFFFFF7F7FFFFF
1 2108A953 0000000000000000 1 1 12 FFFFFFFFFF7FFFFF 1 21180853 0000000000000000 1 1 10 FFFFFFFF00000001
1 E00800D3 0000000000000000 1 0 01 0000000000000001 1 E0090153 0000000000000000 1 0 02 FFFFFFFFFF7FFFFF
1 E00581D3 0000000000000000 1 0 03 FFFFFFFFC0490FDB 1 E0050253 0000000000000000 1 0 04 FFFFFFFFBF800000
1 22F6AA53 0000000000000000 1 1 14 7FFFFFFF22222222 1 E00702D3 0000000000000000 1 0 05 0000000040490FDB
0 00000000 0000000000000000 0 0 00 0000000000000000 0 00000000 0000000000000000 0 0 00 0000000000000000

/* testbench/tb_fpu_cluster.sv */
`include "fpu_config.svh"

module tb_fpu_cluster;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int FIELDS    = 7;                    // Columns per slot
  localparam int LINE_LEN  = FIELDS * `FPU_LANES;
  localparam int MAX_VEC   = 64;
  localparam int LATENCY   = 4;                    // Drive edge to stable write-back

  logic        i_clk;
  logic        i_reset_n;
  logic        i_inst_valid [`FPU_LANES];
  logic [31:0] i_inst       [`FPU_LANES];
  logic [63:0] i_int_data   [`FPU_LANES];
  logic        o_wb_valid   [`FPU_LANES];
  logic        o_wb_fpr     [`FPU_LANES];
  logic [4:0]  o_wb_rd      [`FPU_LANES];
  logic [63:0] o_wb_data    [`FPU_LANES];

  logic [63:0] vec_mem [MAX_VEC * LINE_LEN];
  int          num_vec = 0;
  int          err_cnt = 0;
  int          done_cnt = 0;
  int          neg_cnt = 0;
  int          q_vec [$];   // Vector index awaiting its write-back
  int          q_due [$];   // Negedge count at which it is checked

  fpu_cluster u_fpu_cluster (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_inst_valid (i_inst_valid),
    .i_inst       (i_inst),
    .i_int_data   (i_int_data),
    .o_wb_valid   (o_wb_valid),
    .o_wb_fpr     (o_wb_fpr),
    .o_wb_rd      (o_wb_rd),
    .o_wb_data    (o_wb_data)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("mismatch at %0t ns: %s expected %h got %h", $time, name, expected, actual);
      err_cnt++;
    end
  endtask

  task automatic drive_line(input int n);
    int base;
    for (int s = 0; s < `FPU_LANES; s++) begin
      base = n * LINE_LEN + s * FIELDS;
      i_inst_valid[s] <= vec_mem[base][0];
      i_inst[s]       <= vec_mem[base + 1][31:0];
      i_int_data[s]   <= vec_mem[base + 2];
    end
  endtask

  task automatic drive_idle();
    for (int s = 0; s < `FPU_LANES; s++) begin
      i_inst_valid[s] <= 1'b0;
      i_inst[s]       <= 32'h0;
      i_int_data[s]   <= 64'h0;
    end
  endtask

  // ----------------------------------------
  // Write-back checker
  // ----------------------------------------
  always @(negedge i_clk) begin
    int n;
    int base;
    int err_before;
    if (q_due.size() != 0 && q_due[0] == neg_cnt) begin
      n = q_vec.pop_front();
      void'(q_due.pop_front());
      err_before = err_cnt;
      for (int s = 0; s < `FPU_LANES; s++) begin
        base = n * LINE_LEN + s * FIELDS;
        check_value($sformatf("o_wb_valid[%0d]", s), {63'h0, o_wb_valid[s]},
                    {63'h0, vec_mem[base + 3][0]});
        if (vec_mem[base + 3][0]) begin  // Payload only on a write-back
          check_value($sformatf("o_wb_fpr[%0d]", s), {63'h0, o_wb_fpr[s]},
                      {63'h0, vec_mem[base + 4][0]});
          check_value($sformatf("o_wb_rd[%0d]", s), {59'h0, o_wb_rd[s]},
                      {59'h0, vec_mem[base + 5][4:0]});
          check_value($sformatf("o_wb_data[%0d]", s), o_wb_data[s], vec_mem[base + 6]);
        end
      end
      if (err_cnt == err_before) $display("vector %0d: ok", n);
      else $display("vector %0d: %0d errors", n, err_cnt - err_before);
      done_cnt++;
    end
    neg_cnt++;
  end

  initial begin : watchdog
    wait (num_vec > 0);
    #((num_vec + 20) * 4);
    $display("Timeout: the write-back checks did not finish in time");
    $display("Simulation FAILED");
    $finish;
  end

  initial begin : main_flow
    i_reset_n = 1'b0;
    for (int s = 0; s < `FPU_LANES; s++) begin
      i_inst_valid[s] = 1'b0;
      i_inst[s]       = 32'h0;
      i_int_data[s]   = 64'h0;
    end
    for (int w = 0; w < MAX_VEC * LINE_LEN; w++) vec_mem[w] = '1;  // End marker
    $readmemh("testbench/fpu_cluster_vectors.txt", vec_mem);
    while (num_vec < MAX_VEC && vec_mem[num_vec * LINE_LEN] != '1) num_vec++;
    if (num_vec == 0) begin
      $display("No vectors could be read from the vector file");
      $display("Simulation FAILED");
      $finish;
    end else begin
      repeat (3) @(posedge i_clk);
      i_reset_n <= 1'b1;
      for (int n = 0; n < num_vec; n++) begin
        @(posedge i_clk);
        drive_line(n);
        q_vec.push_back(n);
        q_due.push_back(neg_cnt + LATENCY);
      end
      @(posedge i_clk);
      drive_idle();
      while (q_due.size() != 0) @(posedge i_clk);
      @(posedge i_clk);
      $display("Vectors checked: %0d, errors: %0d", done_cnt, err_cnt);
      if (err_cnt == 0) begin
        $display("Simulation PASSED");
      end else begin
        $display("Simulation FAILED");
      end
      $finish;
    end
  end

endmodule
